// ==== rtl/rp_pkg.sv ====
package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Default channel count
  localparam int N_CH = 2;

  // ADC and DAC sample width
  localparam int SMP_W = 14;

  // Gain word, 2.14 fixed point
  localparam int GAIN_W = 16;
  // Gain of 16384 is unity
  localparam int GAIN_FRAC = 14;

  // Default lockout counter width
  localparam int TMR_W = 20;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Two's complement sample, raw or calibrated
  typedef logic signed [SMP_W-1:0] sample_t;

  // Pin code, unsigned negative slope
  typedef logic [SMP_W-1:0] code_t;

  // Calibration gain and offset
  typedef logic signed [GAIN_W-1:0] gain_t;
  typedef logic signed [SMP_W-1:0] offset_t;

  // Debouncer states
  // HOLD means lockout after an accepted edge to that level
  typedef enum logic [1:0] {
    DEB_IDLE_LOW,
    DEB_IDLE_HIGH,
    DEB_HOLD_LOW,
    DEB_HOLD_HIGH
  } deb_state_t;

endpackage

// ==== rtl/cal_if.sv ====
`timescale 1ns/1ps

interface cal_if #(
  parameter int NCH = rp_pkg::N_CH
) ();

  import rp_pkg::*;

  // ADC calibration, one pair per channel
  gain_t   [NCH-1:0] adc_mul;
  offset_t [NCH-1:0] adc_sum;

  // DAC calibration, one pair per channel
  gain_t   [NCH-1:0] dac_mul;
  offset_t [NCH-1:0] dac_sum;

  // Config side, filled from top level ports
  modport src (
    output adc_mul,
    output adc_sum,
    output dac_mul,
    output dac_sum
  );

  // Receive side, values are quasi-static
  modport adc_sink (input adc_mul, input adc_sum);
  modport dac_sink (input dac_mul, input dac_sum);

endinterface

// ==== rtl/linear_cal.sv ====
`timescale 1ns/1ps

module linear_cal #(
  parameter int GAIN_FRAC_P = rp_pkg::GAIN_FRAC
) (
  input  logic            adc_clk,
  input  logic            top_rst,
  input  rp_pkg::sample_t dat_i,
  input  logic            vld_i,
  input  rp_pkg::gain_t   mul_i,
  input  rp_pkg::offset_t sum_i,
  output rp_pkg::sample_t dat_o,
  output logic            vld_o
);

  import rp_pkg::*;

  // Full product, then what is left after dropping fraction bits
  localparam int PROD_W = SMP_W + GAIN_W;
  localparam int SHR_W  = PROD_W - GAIN_FRAC_P;
  // One extra bit so offset addition never wraps
  localparam int SUM_W  = SHR_W + 1;
  // Clamp limits of sample_t
  localparam int SAT_HI = 2**(SMP_W-1) - 1;
  localparam int SAT_LO = -(2**(SMP_W-1));

  logic signed [PROD_W-1:0] prod_full;
  logic signed [PROD_W-1:0] prod_shr;
  logic signed [SHR_W-1:0]  prod_q;
  logic                     vld_q;
  logic signed [SUM_W-1:0]  sum_full;

  // Signed multiply, arithmetic shift keeps sign
  assign prod_full = dat_i * mul_i;
  assign prod_shr  = prod_full >>> GAIN_FRAC_P;

  // Stage 1, scaled product
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_q  <= 1'b0;
      prod_q <= '0;
    end else begin
      vld_q <= vld_i;
      // Upper bits are pure sign extension here
      if (vld_i) prod_q <= prod_shr[SHR_W-1:0];
    end
  end

  assign sum_full = prod_q + sum_i;

  // Stage 2, offset plus clamp
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      vld_o <= 1'b0;
      dat_o <= '0;
    end else begin
      vld_o <= vld_q;
      if (vld_q) begin
        if (sum_full > SAT_HI)      dat_o <= sample_t'(SAT_HI);
        else if (sum_full < SAT_LO) dat_o <= sample_t'(SAT_LO);
        else                        dat_o <= sum_full[SMP_W-1:0];
      end
    end
  end

endmodule

// ==== rtl/adc_frontend.sv ====
`timescale 1ns/1ps

module adc_frontend #(
  parameter int NCH = rp_pkg::N_CH
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  rp_pkg::code_t   [NCH-1:0] adc_dat_i,
  input  logic                      digital_loop_i,
  input  rp_pkg::sample_t [NCH-1:0] dac_cal_i,
  cal_if.adc_sink                   cal,
  output rp_pkg::sample_t [NCH-1:0] adc_dat_o,
  output logic            [NCH-1:0] adc_vld_o
);

  import rp_pkg::*;

  // ADC samples every clock, stream goes valid one cycle after reset
  logic raw_vld_q;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) raw_vld_q <= 1'b0;
    else         raw_vld_q <= 1'b1;
  end

  for (genvar i = 0; i < NCH; i++) begin : gen_ch

    sample_t conv;
    sample_t raw_q;

    // Negative slope code to two's complement
    // MSB kept, rest inverted
    assign conv = {adc_dat_i[i][SMP_W-1], ~adc_dat_i[i][SMP_W-2:0]};

    // Input register, loopback picks the calibrated DAC value
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst)             raw_q <= '0;
      else if (digital_loop_i) raw_q <= dac_cal_i[i];
      else                     raw_q <= conv;
    end

    // Gain, offset, saturation
    linear_cal #(
      .GAIN_FRAC_P (GAIN_FRAC)
    ) u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (raw_q),
      .vld_i   (raw_vld_q),
      .mul_i   (cal.adc_mul[i]),
      .sum_i   (cal.adc_sum[i]),
      .dat_o   (adc_dat_o[i]),
      .vld_o   (adc_vld_o[i])
    );

  end : gen_ch

endmodule

// ==== rtl/dac_backend.sv ====
`timescale 1ns/1ps

module dac_backend #(
  parameter int NCH = rp_pkg::N_CH
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  rp_pkg::sample_t [NCH-1:0] gen_dat_i,
  input  logic            [NCH-1:0] gen_vld_i,
  cal_if.dac_sink                   cal,
  output rp_pkg::sample_t [NCH-1:0] dac_cal_o,
  output rp_pkg::code_t   [NCH-1:0] dac_dat_o,
  output logic            [NCH-1:0] dac_vld_o
);

  import rp_pkg::*;

  // Pin code for sample zero
  localparam code_t CODE_ZERO = {1'b0, {(SMP_W-1){1'b1}}};

  for (genvar i = 0; i < NCH; i++) begin : gen_ch

    logic  cal_vld;
    code_t code_q;
    logic  vld_q;

    // Calibrated sample, also tapped for loopback
    linear_cal #(
      .GAIN_FRAC_P (GAIN_FRAC)
    ) u_cal (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .dat_i   (gen_dat_i[i]),
      .vld_i   (gen_vld_i[i]),
      .mul_i   (cal.dac_mul[i]),
      .sum_i   (cal.dac_sum[i]),
      .dat_o   (dac_cal_o[i]),
      .vld_o   (cal_vld)
    );

    // Output register, back to negative slope
    // Code held between strobes
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        vld_q  <= 1'b0;
        code_q <= CODE_ZERO;
      end else begin
        vld_q <= cal_vld;
        if (cal_vld) code_q <= {dac_cal_o[i][SMP_W-1], ~dac_cal_o[i][SMP_W-2:0]};
      end
    end

    assign dac_dat_o[i] = code_q;
    assign dac_vld_o[i] = vld_q;

  end : gen_ch

endmodule

// ==== rtl/debounce_fsm.sv ====
`timescale 1ns/1ps

module debounce_fsm #(
  parameter int CW = rp_pkg::TMR_W
) (
  input  logic          adc_clk,
  input  logic          top_rst,
  input  logic          gpio_i,
  input  logic [CW-1:0] len_i,
  input  logic          tmr_done_i,
  output logic          tmr_load_o,
  output logic [CW-1:0] tmr_len_o,
  output logic          trg_pos_o,
  output logic          trg_neg_o
);

  import rp_pkg::*;

  logic       sync_q1;
  logic       sync_q2;
  deb_state_t state_q;
  deb_state_t state_nxt;
  logic       pos_nxt;
  logic       neg_nxt;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Edge acceptance
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt  = state_q;
    tmr_load_o = 1'b0;
    pos_nxt    = 1'b0;
    neg_nxt    = 1'b0;
    case (state_q)
      DEB_IDLE_LOW: begin
        if (sync_q2) begin
          state_nxt  = DEB_HOLD_HIGH;
          pos_nxt    = 1'b1;
          tmr_load_o = 1'b1;
        end
      end
      DEB_IDLE_HIGH: begin
        if (!sync_q2) begin
          state_nxt  = DEB_HOLD_LOW;
          neg_nxt    = 1'b1;
          tmr_load_o = 1'b1;
        end
      end
      // Lockout over, a pending level change counts right away
      DEB_HOLD_LOW: begin
        if (tmr_done_i && sync_q2) begin
          state_nxt  = DEB_HOLD_HIGH;
          pos_nxt    = 1'b1;
          tmr_load_o = 1'b1;
        end else if (tmr_done_i) begin
          state_nxt = DEB_IDLE_LOW;
        end
      end
      DEB_HOLD_HIGH: begin
        if (tmr_done_i && !sync_q2) begin
          state_nxt  = DEB_HOLD_LOW;
          neg_nxt    = 1'b1;
          tmr_load_o = 1'b1;
        end else if (tmr_done_i) begin
          state_nxt = DEB_IDLE_HIGH;
        end
      end
      default: state_nxt = DEB_IDLE_LOW;
    endcase
  end

  // Zero length would wrap the timer, treat as one cycle
  assign tmr_len_o = (len_i == '0) ? CW'(1) : len_i;

  // State and strobes change on the same edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      state_q   <= DEB_IDLE_LOW;
      trg_pos_o <= 1'b0;
      trg_neg_o <= 1'b0;
    end else begin
      state_q   <= state_nxt;
      trg_pos_o <= pos_nxt;
      trg_neg_o <= neg_nxt;
    end
  end

endmodule

// ==== rtl/hold_timer.sv ====
`timescale 1ns/1ps

module hold_timer #(
  parameter int CW = rp_pkg::TMR_W
) (
  input  logic          adc_clk,
  input  logic          top_rst,
  input  logic          load_i,
  input  logic [CW-1:0] len_i,
  output logic          done_o
);

  logic [CW-1:0] cnt_q;
  logic          busy_q;

  // Load wins over countdown, so back to back lockouts restart cleanly
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (load_i) begin
      cnt_q  <= len_i;
      busy_q <= 1'b1;
    end else if (busy_q) begin
      cnt_q <= cnt_q - 1'b1;
      // Count hits zero on this edge
      if (cnt_q == CW'(1)) busy_q <= 1'b0;
    end
  end

  // High in the last lockout cycle, len_i cycles after the load
  assign done_o = busy_q && (cnt_q == CW'(1));

endmodule

// ==== rtl/rp_analog_top.sv ====
`timescale 1ns/1ps

module rp_analog_top #(
  parameter int NCH = rp_pkg::N_CH,
  parameter int CW  = rp_pkg::TMR_W
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // ADC pins
  input  rp_pkg::code_t   [NCH-1:0] adc_dat_i,
  // Generator stream
  input  rp_pkg::sample_t [NCH-1:0] gen_dat_i,
  input  logic            [NCH-1:0] gen_vld_i,
  // Config
  input  logic                      digital_loop_i,
  input  rp_pkg::gain_t   [NCH-1:0] adc_mul_i,
  input  rp_pkg::offset_t [NCH-1:0] adc_sum_i,
  input  rp_pkg::gain_t   [NCH-1:0] dac_mul_i,
  input  rp_pkg::offset_t [NCH-1:0] dac_sum_i,
  // Trigger input and lockout length
  input  logic                      gpio_i,
  input  logic            [CW-1:0]  deb_len_i,
  // Acquisition stream
  output rp_pkg::sample_t [NCH-1:0] adc_dat_o,
  output logic            [NCH-1:0] adc_vld_o,
  // DAC pins
  output rp_pkg::code_t   [NCH-1:0] dac_dat_o,
  output logic            [NCH-1:0] dac_vld_o,
  // Edge triggers
  output logic                      trg_pos_o,
  output logic                      trg_neg_o
);

  import rp_pkg::*;

  // DAC side calibrated samples for loopback
  sample_t [NCH-1:0] dac_cal;

  // Debouncer to lockout timer
  logic          tmr_load;
  logic [CW-1:0] tmr_len;
  logic          tmr_done;

  //////////////////////////////////////////////////////////////////////
  // Calibration values
  //////////////////////////////////////////////////////////////////////

  cal_if #(.NCH (NCH)) cal ();

  assign cal.adc_mul = adc_mul_i;
  assign cal.adc_sum = adc_sum_i;
  assign cal.dac_mul = dac_mul_i;
  assign cal.dac_sum = dac_sum_i;

  //////////////////////////////////////////////////////////////////////
  // Analog paths
  //////////////////////////////////////////////////////////////////////

  adc_frontend #(
    .NCH (NCH)
  ) u_adc (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat_i),
    .digital_loop_i (digital_loop_i),
    .dac_cal_i      (dac_cal),
    .cal            (cal.adc_sink),
    .adc_dat_o      (adc_dat_o),
    .adc_vld_o      (adc_vld_o)
  );

  dac_backend #(
    .NCH (NCH)
  ) u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_dat_i (gen_dat_i),
    .gen_vld_i (gen_vld_i),
    .cal       (cal.dac_sink),
    .dac_cal_o (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_vld_o (dac_vld_o)
  );

  //////////////////////////////////////////////////////////////////////
  // GPIO trigger
  //////////////////////////////////////////////////////////////////////

  debounce_fsm #(
    .CW (CW)
  ) u_deb (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gpio_i     (gpio_i),
    .len_i      (deb_len_i),
    .tmr_done_i (tmr_done),
    .tmr_load_o (tmr_load),
    .tmr_len_o  (tmr_len),
    .trg_pos_o  (trg_pos_o),
    .trg_neg_o  (trg_neg_o)
  );

  hold_timer #(
    .CW (CW)
  ) u_tmr (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .load_i  (tmr_load),
    .len_i   (tmr_len),
    .done_o  (tmr_done)
  );

endmodule

// ==== testbench/tb_rp_analog.sv ====
`timescale 1ns/1ps

module tb_rp_analog;

  import rp_pkg::*;

  localparam int NCH = 2;
  localparam int CW  = 20;

  // Test phases
  localparam int PH_CAL  = 0;
  localparam int PH_SAT  = 1;
  localparam int PH_LOOP = 2;
  localparam int PH_DEB  = 3;

  // Phase lengths in clock cycles
  localparam int LEN_CAL  = 400;
  localparam int LEN_SAT  = 300;
  localparam int LEN_LOOP = 300;
  localparam int LEN_DEB  = 400;
  // Strobe-free cycles before cal values move
  localparam int QUIET    = 3;
  localparam int RUN_CYC  = LEN_CAL + LEN_SAT + LEN_LOOP + LEN_DEB + 4 * QUIET + 2;
  localparam int CYC_LIMIT = RUN_CYC + 64;

  // Sample range and pin code mask
  localparam longint SMAX = 2**(SMP_W-1) - 1;
  localparam longint SMIN = -(2**(SMP_W-1));
  localparam code_t CODE_MASK = code_t'(2**(SMP_W-1) - 1);

  // Expected ADC output
  // Data check off while cal values settle
  typedef struct packed {
    logic                vld;
    logic                chk;
    sample_t [NCH-1:0]   dat;
  } adc_exp_t;

  // Generator strobe with its calibrated sample
  typedef struct packed {
    logic    [NCH-1:0]   vld;
    sample_t [NCH-1:0]   cal;
  } dac_exp_t;

  logic              adc_clk;
  logic              top_rst;
  code_t   [NCH-1:0] adc_dat;
  sample_t [NCH-1:0] gen_dat;
  logic    [NCH-1:0] gen_vld;
  logic              digital_loop;
  gain_t   [NCH-1:0] adc_mul;
  offset_t [NCH-1:0] adc_sum;
  gain_t   [NCH-1:0] dac_mul;
  offset_t [NCH-1:0] dac_sum;
  logic              gpio;
  logic    [CW-1:0]  deb_len;
  sample_t [NCH-1:0] adc_dat_o;
  logic    [NCH-1:0] adc_vld_o;
  code_t   [NCH-1:0] dac_dat_o;
  logic    [NCH-1:0] dac_vld_o;
  logic              trg_pos_o;
  logic              trg_neg_o;

  //////////////////////////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////////////////////////

  adc_exp_t          adc_q[$];
  dac_exp_t          dac_q[$];
  logic              gpio_hist[$];
  // DAC cal register and held pin code as seen by the model
  sample_t [NCH-1:0] dac_cal_mdl;
  code_t   [NCH-1:0] held_code;
  // Debouncer accepted level, lockout cycles left and next strobes
  logic              acc_lvl;
  int                hold_left;
  logic    [1:0]     trg_exp;
  // GPIO toggles when this many random bits are all zero
  int                tog_w;
  logic    [31:0]    lfsr_st;
  int                cyc_cnt;

  rp_analog_top #(
    .NCH (NCH),
    .CW  (CW)
  ) dut (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat),
    .gen_dat_i      (gen_dat),
    .gen_vld_i      (gen_vld),
    .digital_loop_i (digital_loop),
    .adc_mul_i      (adc_mul),
    .adc_sum_i      (adc_sum),
    .dac_mul_i      (dac_mul),
    .dac_sum_i      (dac_sum),
    .gpio_i         (gpio),
    .deb_len_i      (deb_len),
    .adc_dat_o      (adc_dat_o),
    .adc_vld_o      (adc_vld_o),
    .dac_dat_o      (dac_dat_o),
    .dac_vld_o      (dac_vld_o),
    .trg_pos_o      (trg_pos_o),
    .trg_neg_o      (trg_neg_o)
  );

  // 4 ns clock
  always #2 adc_clk = ~adc_clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb      = lfsr_st[31] ^ lfsr_st[21] ^ lfsr_st[1] ^ lfsr_st[0];
      lfsr_st = {lfsr_st[30:0], fb};
      r       = {r[30:0], fb};
    end
    return r;
  endfunction

  // Pin code to two's complement by flipping the low bits
  function automatic sample_t code_to_sample(input code_t c);
    return sample_t'(c ^ CODE_MASK);
  endfunction

  function automatic code_t sample_to_code(input sample_t s);
    return code_t'(s) ^ CODE_MASK;
  endfunction

  // Gain in 2.14 followed by offset and clamp
  function automatic sample_t calibrate(input sample_t s, input gain_t g, input offset_t o);
    longint p;
    p = longint'(s) * longint'(g);
    // Floor division by 2^14
    p = p >>> GAIN_FRAC;
    p = p + longint'(o);
    if (p > SMAX) p = SMAX;
    else if (p < SMIN) p = SMIN;
    return sample_t'(p);
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_sample(input string what, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_code(input string what, input code_t got, input code_t exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is 'h%h, expected 'h%h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_valid(input string what, input logic [NCH-1:0] got,
                             input logic [NCH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Edge kind as {pos, neg}
  task automatic check_trig(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t: trigger pos/neg is %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle to check, advance the model and drive
  //////////////////////////////////////////////////////////////////////

  task automatic step(input logic gen_en);
    adc_exp_t ae;
    dac_exp_t de;
    logic     s;
    logic     r;
    int       ch;
    // ADC result of the inputs driven 3 cycles ago
    ae = adc_q.pop_front();
    check_valid("adc_vld_o", adc_vld_o, {NCH{ae.vld}});
    for (ch = 0; ch < NCH; ch++) begin
      if (ae.chk) check_sample($sformatf("adc_dat_o[%0d]", ch), adc_dat_o[ch], ae.dat[ch]);
    end
    // DAC pins hold their code between strobes
    de = dac_q.pop_front();
    check_valid("dac_vld_o", dac_vld_o, de.vld);
    for (ch = 0; ch < NCH; ch++) begin
      if (de.vld[ch]) held_code[ch] = sample_to_code(de.cal[ch]);
      check_code($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], held_code[ch]);
    end
    // Strobe from 2 cycles ago just reached the DAC cal register
    de = dac_q[0];
    for (ch = 0; ch < NCH; ch++) begin
      if (de.vld[ch]) dac_cal_mdl[ch] = de.cal[ch];
    end
    check_trig({trg_pos_o, trg_neg_o}, trg_exp);
    // Debouncer sees the GPIO level from 2 cycles back
    s       = gpio_hist.pop_front();
    trg_exp = 2'b00;
    if (hold_left > 1) begin
      hold_left--;
    end else begin
      // Idle or in the last lockout cycle
      hold_left = 0;
      if (s != acc_lvl) begin
        acc_lvl   = s;
        trg_exp   = s ? 2'b10 : 2'b01;
        hold_left = int'(deb_len);
      end
    end
    // New stimulus
    for (ch = 0; ch < NCH; ch++) begin
      adc_dat[ch] = code_t'(take_bits(SMP_W));
      gen_dat[ch] = sample_t'(take_bits(SMP_W));
      r           = 1'(take_bits(1));
      gen_vld[ch] = gen_en & r;
    end
    if (take_bits(tog_w) == 0) gpio = ~gpio;
    // Expected values for what was just driven
    ae.vld = 1'b1;
    ae.chk = 1'b1;
    de.vld = gen_vld;
    for (ch = 0; ch < NCH; ch++) begin
      if (digital_loop) ae.dat[ch] = calibrate(dac_cal_mdl[ch], adc_mul[ch], adc_sum[ch]);
      else ae.dat[ch] = calibrate(code_to_sample(adc_dat[ch]), adc_mul[ch], adc_sum[ch]);
      de.cal[ch] = calibrate(gen_dat[ch], dac_mul[ch], dac_sum[ch]);
    end
    adc_q.push_back(ae);
    dac_q.push_back(de);
    gpio_hist.push_back(gpio);
    @(posedge adc_clk);
    #1;
  endtask

  // Cal values for one phase
  // In-flight ADC samples mix old and new values
  task automatic set_config(input int kind);
    adc_exp_t ae;
    int       ch;
    int       i;
    for (ch = 0; ch < NCH; ch++) begin
      if (kind == PH_SAT) begin
        adc_mul[ch] = gain_t'(take_bits(GAIN_W));
        dac_mul[ch] = gain_t'(take_bits(GAIN_W));
        adc_sum[ch] = offset_t'(take_bits(SMP_W));
        dac_sum[ch] = offset_t'(take_bits(SMP_W));
      end else begin
        // Near unity gains with small offsets
        adc_mul[ch] = gain_t'(16384 + int'(take_bits(10)) - 512);
        dac_mul[ch] = gain_t'(16384 + int'(take_bits(10)) - 512);
        adc_sum[ch] = offset_t'(int'(take_bits(8)) - 128);
        dac_sum[ch] = offset_t'(int'(take_bits(8)) - 128);
      end
    end
    digital_loop = (kind == PH_LOOP);
    if (kind == PH_DEB) begin
      deb_len = CW'(1 + take_bits(2) % 3);
      tog_w   = 1;
    end else begin
      deb_len = CW'(2 + take_bits(2));
      tog_w   = 3;
    end
    for (i = 0; i < adc_q.size(); i++) begin
      ae        = adc_q[i];
      ae.chk    = 1'b0;
      adc_q[i]  = ae;
    end
  endtask

  task automatic run_phase(input int kind, input int ncyc);
    int i;
    for (i = 0; i < QUIET; i++) step(1'b0);
    set_config(kind);
    for (i = 0; i < ncyc; i++) step(1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk      = 1'b0;
    top_rst      = 1'b1;
    adc_dat      = '0;
    gen_dat      = '0;
    gen_vld      = '0;
    digital_loop = 1'b0;
    adc_mul      = {NCH{gain_t'(16384)}};
    dac_mul      = {NCH{gain_t'(16384)}};
    adc_sum      = '0;
    dac_sum      = '0;
    gpio         = 1'b0;
    deb_len      = CW'(4);
    lfsr_st      = 32'h1d72_5a12;
    tog_w        = 3;
    dac_cal_mdl  = '0;
    held_code    = {NCH{sample_to_code('0)}};
    acc_lvl      = 1'b0;
    hold_left    = 0;
    trg_exp      = 2'b00;
    // Pipelines start empty with outputs at reset values
    repeat (3) adc_q.push_back('0);
    repeat (3) dac_q.push_back('0);
    repeat (2) gpio_hist.push_back(1'b0);
    repeat (2) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;
    run_phase(PH_CAL, LEN_CAL);
    run_phase(PH_SAT, LEN_SAT);
    run_phase(PH_LOOP, LEN_LOOP);
    run_phase(PH_DEB, LEN_DEB);
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog
  initial cyc_cnt = 0;

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt > CYC_LIMIT) begin
      $display("Timeout: run took more than %0d clock cycles", CYC_LIMIT);
      abort_run();
    end
  end

endmodule

// ==== flist.f ====
rtl/rp_pkg.sv
rtl/cal_if.sv
rtl/linear_cal.sv
rtl/adc_frontend.sv
rtl/dac_backend.sv
rtl/debounce_fsm.sv
rtl/hold_timer.sv
rtl/rp_analog_top.sv
testbench/tb_rp_analog.sv

// ==== Bender.yml ====
package:
  name: rp_analog

sources:
  - rtl/rp_pkg.sv
  - rtl/cal_if.sv
  - rtl/linear_cal.sv
  - rtl/adc_frontend.sv
  - rtl/dac_backend.sv
  - rtl/debounce_fsm.sv
  - rtl/hold_timer.sv
  - rtl/rp_analog_top.sv
  - target: test
    files:
      - testbench/tb_rp_analog.sv
